//--- all.f
hw/irq_cfg_pkg.sv
hw/irq_csr_pkg.sv
hw/irq_if.sv
hw/irq_sync.sv
hw/irq_csr_unit.sv
hw/irq_priority.sv
hw/irq_top.sv
verif/irq_sva.sv
verif/irq_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= irq_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/irq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module irq_tb
    import irq_cfg_pkg::*, irq_csr_pkg::*;
();

    localparam int PLANNED_CYCLES = 600;
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;
    localparam int RANDOM_CYCLES  = 300;

    logic                    clk_i = 1'b0;
    logic                    arst_n;
    logic [NUM_IRQ-1:0]      irq_n;
    logic                    stall_x;
    logic                    exc;
    logic                    dbg_exc;
    logic                    eret;
    logic                    bret;
    csr_addr_e               csr_addr;
    logic [WORD_WIDTH-1:0]   csr_wdata;
    logic                    csr_we;
    logic [WORD_WIDTH-1:0]   csr_rdata;
    logic                    irq_req;
    logic [IRQ_ID_WIDTH-1:0] irq_id;
    logic                    irq_valid;

    // Model copies of the DUT state
    logic [NUM_IRQ-1:0]      m_sync0;
    logic [NUM_IRQ-1:0]      m_sync1;
    logic [NUM_IRQ-1:0]      m_im;
    logic [NUM_IRQ-1:0]      m_ip;
    logic                    m_ie;
    logic                    m_eie;
    logic                    m_bie;
    logic                    m_valid;
    logic [IRQ_ID_WIDTH-1:0] m_id;

    logic [31:0] lcg_state = 32'd5530;
    int          cycle_count = 0;

    always #20 clk_i = ~clk_i;

    irq_top i_dut
    (
        .clk_i     (clk_i),
        .arst_n    (arst_n),
        .irq_n     (irq_n),
        .stall_x   (stall_x),
        .exc       (exc),
        .dbg_exc   (dbg_exc),
        .eret      (eret),
        .bret      (bret),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .csr_we    (csr_we),
        .csr_rdata (csr_rdata),
        .irq_req   (irq_req),
        .irq_id    (irq_id),
        .irq_valid (irq_valid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [IRQ_ID_WIDTH-1:0] lowest_pending(input logic [NUM_IRQ-1:0] v);
        for (int i = 0; i < NUM_IRQ; i++)
        begin
            if (v[i])
            begin
                return IRQ_ID_WIDTH'(i);
            end
        end
        return '0;
    endfunction

    function automatic logic exp_req();
        return m_ie && (|(m_ip & m_im));
    endfunction

    function automatic logic [WORD_WIDTH-1:0] exp_rdata(input csr_addr_e addr);
        logic [WORD_WIDTH-1:0] w;
        w = '0;
        case (addr)
            CSR_IE:
            begin
                w[IE_BIT]  = m_ie;
                w[EIE_BIT] = m_eie;
                w[BIE_BIT] = m_bie;
            end
            CSR_IM:  w[NUM_IRQ-1:0] = m_im;
            CSR_IP:  w[NUM_IRQ-1:0] = m_ip;
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic void ref_reset();
        m_sync0 = '1;  // Idle pins
        m_sync1 = '1;
        m_im    = '0;
        m_ip    = '0;
        m_ie    = 1'b0;
        m_eie   = 1'b0;
        m_bie   = 1'b0;
        m_valid = 1'b0;
        m_id    = '0;
    endfunction

    // One clock edge of the model with the inputs held over the last cycle
    function automatic void ref_step();
        logic [NUM_IRQ-1:0] level;
        logic [NUM_IRQ-1:0] clr;
        logic               wr;
        level = ~m_sync1;
        wr    = csr_we && !stall_x && !exc && !dbg_exc && !eret && !bret;
        clr   = (wr && csr_addr == CSR_IP) ? csr_wdata[NUM_IRQ-1:0] : '0;
        m_valid = exp_req();
        if (|(m_ip & m_im))
        begin
            m_id = lowest_pending(m_ip & m_im);
        end
        if (exc)
        begin
            m_eie = m_ie;
            m_ie  = 1'b0;
        end
        else if (dbg_exc)
        begin
            m_bie = m_ie;
            m_ie  = 1'b0;
        end
        else if (!stall_x && eret)
        begin
            m_ie = m_eie;
        end
        else if (!stall_x && bret)
        begin
            m_ie = m_bie;
        end
        else if (wr && csr_addr == CSR_IE)
        begin
            m_ie  = csr_wdata[IE_BIT];
            m_eie = csr_wdata[EIE_BIT];
            m_bie = csr_wdata[BIE_BIT];
        end
        if (wr && csr_addr == CSR_IM)
        begin
            m_im = csr_wdata[NUM_IRQ-1:0];
        end
        m_ip    = (m_ip & ~clr) | level;
        m_sync1 = m_sync0;
        m_sync0 = irq_n;
    endfunction

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at cycle %0d", cycle_count);
    endtask

    task automatic check_word(input string name, input logic [WORD_WIDTH-1:0] got,
                              input logic [WORD_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_id(input string name, input logic [IRQ_ID_WIDTH-1:0] got,
                            input logic [IRQ_ID_WIDTH-1:0] exp);
        if (got !== exp)
        begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic clear_strobes();
        stall_x = 1'b0;
        exc     = 1'b0;
        dbg_exc = 1'b0;
        eret    = 1'b0;
        bret    = 1'b0;
        csr_we  = 1'b0;
    endtask

    task automatic csr_write(input csr_addr_e addr, input logic [WORD_WIDTH-1:0] data,
                             input logic stall);
        next_cycle();
        csr_addr  = addr;
        csr_wdata = data;
        csr_we    = 1'b1;
        stall_x   = stall;
        next_cycle();
        clear_strobes();
    endtask

    task automatic pulse_event(input logic exc_v, input logic dbg_v, input logic eret_v,
                               input logic bret_v, input logic stall_v);
        next_cycle();
        exc     = exc_v;
        dbg_exc = dbg_v;
        eret    = eret_v;
        bret    = bret_v;
        stall_x = stall_v;
        next_cycle();
        clear_strobes();
    endtask

    always @(posedge clk_i)
    begin
        if (!arst_n)
        begin
            ref_reset();
        end
        else
        begin
            ref_step();
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk_i)
    begin
        check_word("csr_rdata", csr_rdata, exp_rdata(csr_addr));
        check_bit("irq_req", irq_req, exp_req());
        check_bit("irq_valid", irq_valid, m_valid);
        check_id("irq_id", irq_id, m_id);
    end

    always @(posedge clk_i)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] e;
        ref_reset();
        arst_n    = 1'b0;
        irq_n     = '1;
        csr_addr  = CSR_IE;
        csr_wdata = '0;
        clear_strobes();
        repeat (5) @(posedge clk_i);
        #2 arst_n = 1'b1;

        // Reset values of all three CSRs
        next_cycle();
        csr_addr = CSR_IM;
        next_cycle();
        csr_addr = CSR_IP;

        // Read back of written values and of stalled writes
        csr_write(CSR_IE, 32'hffff_fffd, 1'b0);
        csr_write(CSR_IM, 32'h0000_00a5, 1'b0);
        csr_write(CSR_IM, 32'h0000_005a, 1'b1);
        csr_write(CSR_IE, 32'h0000_0000, 1'b1);

        // Pin 0 reaches IP on the third edge
        next_cycle();
        csr_addr = CSR_IP;
        irq_n[0] = 1'b0;
        repeat (3)
        begin
            @(negedge clk_i);
            check_word("csr_rdata", csr_rdata, 32'h0);
        end
        @(negedge clk_i);
        check_word("csr_rdata", csr_rdata, 32'h1);

        // Clear while the pin is held and again after release
        csr_write(CSR_IP, 32'h1, 1'b0);
        @(negedge clk_i);
        check_word("csr_rdata", csr_rdata, 32'h1);
        next_cycle();
        irq_n = '1;
        repeat (3) next_cycle();
        csr_write(CSR_IP, 32'h1, 1'b0);
        @(negedge clk_i);
        check_word("csr_rdata", csr_rdata, 32'h0);

        // Save and restore of the enable bit
        csr_write(CSR_IE, 32'h1, 1'b0);
        pulse_event(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        pulse_event(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        pulse_event(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        pulse_event(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        pulse_event(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);  // Exception beats eret
        pulse_event(1'b0, 1'b0, 1'b1, 1'b0, 1'b1);  // Stalled eret
        pulse_event(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);

        // Unmapped indices
        csr_write(csr_addr_e'(5'd9), 32'hffff_ffff, 1'b0);
        @(negedge clk_i);
        check_word("csr_rdata", csr_rdata, 32'h0);
        next_cycle();
        csr_addr = csr_addr_e'(5'd31);
        next_cycle();
        csr_addr = CSR_IM;

        for (int n = 0; n < RANDOM_CYCLES; n++)
        begin
            next_cycle();
            r = lcg_next();
            e = lcg_next();
            irq_n     = r[7:0] | r[15:8];  // Each pin low a quarter of the time
            csr_we    = (r[18:16] == 3'd0);
            csr_addr  = csr_addr_e'({3'b000, r[20:19]});
            csr_wdata = lcg_next();
            stall_x   = (e[2:0] == 3'd0);
            exc       = (e[7:3] == 5'd0);
            dbg_exc   = (e[7:3] == 5'd1);
            eret      = (e[7:3] == 5'd2);
            bret      = (e[7:3] == 5'd3);
        end

        next_cycle();
        clear_strobes();
        irq_n = '1;
        repeat (4) next_cycle();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/irq_sva.sv
`timescale 1ns/1ps
`default_nettype none

module irq_sva
    import irq_cfg_pkg::*, irq_csr_pkg::*;
(
    input logic               clk_i,
    input logic               arst_n,
    input logic               exc,
    input logic               stall_x,
    input logic               ie,
    input logic [NUM_IRQ-1:0] im,
    input logic               irq_req
);

    // Exception always drops the global enable
    exc_clears_ie: assert property (@(posedge clk_i) disable iff (!arst_n)
        exc |=> !ie)
        else $error("IE still set after an exception");

    req_needs_ie: assert property (@(posedge clk_i) disable iff (!arst_n)
        !ie |-> !irq_req)
        else $error("irq_req high with IE clear");

    // Mask only changes through unstalled writes
    stall_holds_im: assert property (@(posedge clk_i) disable iff (!arst_n)
        stall_x |=> $stable(im))
        else $error("IM changed during a stall");

endmodule

bind irq_csr_unit irq_sva i_sva
(
    .clk_i   (clk_i),
    .arst_n  (arst_n),
    .exc     (evt.exc),
    .stall_x (evt.stall_x),
    .ie      (ie),
    .im      (im),
    .irq_req (irq_req)
);

`default_nettype wire

//--- hw/irq_top.sv
`timescale 1ns/1ps
`default_nettype none

module irq_top import irq_cfg_pkg::*, irq_csr_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n,
    input  logic [NUM_IRQ-1:0]      irq_n,
    // Pipeline strobes
    input  logic                    stall_x,
    input  logic                    exc,
    input  logic                    dbg_exc,
    input  logic                    eret,
    input  logic                    bret,
    // CSR access
    input  csr_addr_e               csr_addr,
    input  logic [WORD_WIDTH-1:0]   csr_wdata,
    input  logic                    csr_we,
    output logic [WORD_WIDTH-1:0]   csr_rdata,
    // Interrupt request and dispatch number
    output logic                    irq_req,
    output logic [IRQ_ID_WIDTH-1:0] irq_id,
    output logic                    irq_valid
);

    csr_if      csr_bus ();
    pipe_evt_if evt_bus ();

    logic [NUM_IRQ-1:0] irq_level;
    logic [NUM_IRQ-1:0] pend_masked;

    assign csr_bus.addr  = csr_addr;
    assign csr_bus.wdata = csr_wdata;
    assign csr_bus.we    = csr_we;
    assign csr_rdata     = csr_bus.rdata;

    assign evt_bus.stall_x = stall_x;
    assign evt_bus.exc     = exc;
    assign evt_bus.dbg_exc = dbg_exc;
    assign evt_bus.eret    = eret;
    assign evt_bus.bret    = bret;

    irq_sync i_sync
    (
        .clk_i     (clk_i),
        .arst_n    (arst_n),
        .irq_n     (irq_n),
        .irq_level (irq_level)
    );

    irq_csr_unit i_csr
    (
        .clk_i       (clk_i),
        .arst_n      (arst_n),
        .csr         (csr_bus.slave),
        .evt         (evt_bus.sink),
        .irq_level   (irq_level),
        .pend_masked (pend_masked),
        .irq_req     (irq_req)
    );

    irq_priority i_prio
    (
        .clk_i       (clk_i),
        .arst_n      (arst_n),
        .pend_masked (pend_masked),
        .irq_req     (irq_req),
        .irq_id      (irq_id),
        .irq_valid   (irq_valid)
    );

endmodule

`default_nettype wire

//--- hw/irq_priority.sv
`timescale 1ns/1ps
`default_nettype none

module irq_priority import irq_cfg_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    arst_n,
    input  logic [NUM_IRQ-1:0]      pend_masked,
    input  logic                    irq_req,
    output logic [IRQ_ID_WIDTH-1:0] irq_id,
    output logic                    irq_valid
);

    logic [IRQ_ID_WIDTH-1:0] low_id;

    // Scan downwards so the lowest set bit is the last one kept
    always_comb
    begin
        low_id = '0;
        for (int i = NUM_IRQ - 1; i >= 0; i--)
        begin
            if (pend_masked[i])
            begin
                low_id = IRQ_ID_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n)
    begin
        if (!arst_n)
        begin
            irq_id    <= '0;
            irq_valid <= 1'b0;
        end
        else
        begin
            irq_valid <= irq_req;
            if (|pend_masked)
            begin
                irq_id <= low_id;  // Otherwise hold last number
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/irq_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module irq_csr_unit import irq_cfg_pkg::*, irq_csr_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n,
    csr_if.slave               csr,
    pipe_evt_if.sink           evt,
    input  logic [NUM_IRQ-1:0] irq_level,
    output logic [NUM_IRQ-1:0] pend_masked,
    output logic               irq_req
);

    logic               ie;
    logic               eie;
    logic               bie;
    logic [NUM_IRQ-1:0] im;
    logic [NUM_IRQ-1:0] ip;

    logic                  csr_wr_en;
    logic [WORD_WIDTH-1:0] ie_word;
    logic [NUM_IRQ-1:0]    ip_clr;

    // A write only lands when no exception or return owns this cycle
    assign csr_wr_en = csr.we && !evt.exc && !evt.dbg_exc && !evt.stall_x
                       && !evt.eret && !evt.bret;

    assign ip_clr = (csr_wr_en && csr.addr == CSR_IP) ? csr.wdata[NUM_IRQ-1:0] : '0;

    assign pend_masked = ip & im;
    assign irq_req     = ie && (|pend_masked);

    always_comb
    begin
        ie_word          = '0;
        ie_word[IE_BIT]  = ie;
        ie_word[EIE_BIT] = eie;
        ie_word[BIE_BIT] = bie;
    end

    always_comb
    begin
        case (csr.addr)
            CSR_IE:  csr.rdata = ie_word;
            CSR_IM:  csr.rdata = WORD_WIDTH'(im);
            CSR_IP:  csr.rdata = WORD_WIDTH'(ip);
            default: csr.rdata = '0;  // Unmapped index
        endcase
    end

    // Enable bits with save and restore
    always_ff @(posedge clk_i or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ie  <= 1'b0;
            eie <= 1'b0;
            bie <= 1'b0;
        end
        else if (evt.exc)
        begin
            eie <= ie;
            ie  <= 1'b0;
        end
        else if (evt.dbg_exc)
        begin
            bie <= ie;
            ie  <= 1'b0;
        end
        else if (!evt.stall_x)
        begin
            if (evt.eret)
            begin
                ie <= eie;
            end
            else if (evt.bret)
            begin
                ie <= bie;
            end
            else if (csr.we && csr.addr == CSR_IE)
            begin
                ie  <= csr.wdata[IE_BIT];
                eie <= csr.wdata[EIE_BIT];
                bie <= csr.wdata[BIE_BIT];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n)
    begin
        if (!arst_n)
        begin
            im <= '0;
            ip <= '0;
        end
        else
        begin
            if (csr_wr_en && csr.addr == CSR_IM)
            begin
                im <= csr.wdata[NUM_IRQ-1:0];
            end
            // Level still asserted wins over a clear
            ip <= (ip & ~ip_clr) | irq_level;
        end
    end

endmodule

`default_nettype wire

//--- hw/irq_sync.sv
`timescale 1ns/1ps
`default_nettype none

module irq_sync import irq_cfg_pkg::*;
(
    input  logic               clk_i,
    input  logic               arst_n,
    input  logic [NUM_IRQ-1:0] irq_n,      // Asynchronous, active low
    output logic [NUM_IRQ-1:0] irq_level   // Synchronized, active high
);

    logic [NUM_IRQ-1:0] sync_q [SYNC_STAGES];

    always_ff @(posedge clk_i or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int s = 0; s < SYNC_STAGES; s++)
            begin
                sync_q[s] <= '1;  // Pins idle high
            end
        end
        else
        begin
            sync_q[0] <= irq_n;
            for (int s = 1; s < SYNC_STAGES; s++)
            begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    assign irq_level = ~sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- hw/irq_if.sv
`timescale 1ns/1ps
`default_nettype none

// CSR read/write port of the interrupt block
interface csr_if import irq_cfg_pkg::*, irq_csr_pkg::*; ();

    csr_addr_e             addr;
    logic [WORD_WIDTH-1:0] wdata;
    logic                  we;     // One-cycle write strobe
    logic [WORD_WIDTH-1:0] rdata;  // Combinational from addr

    modport master (output addr, output wdata, output we, input rdata);
    modport slave (input addr, input wdata, input we, output rdata);

endinterface

// Strobes coming from the execute stage
interface pipe_evt_if ();

    logic stall_x;  // Holds off returns and writes
    logic exc;      // Ordinary exception
    logic dbg_exc;  // Debug exception
    logic eret;
    logic bret;

    modport source (output stall_x, output exc, output dbg_exc, output eret, output bret);
    modport sink (input stall_x, input exc, input dbg_exc, input eret, input bret);

endinterface

`default_nettype wire

//--- hw/irq_csr_pkg.sv
`default_nettype none

package irq_csr_pkg;

    localparam int CSR_ADDR_WIDTH = 5;

    // Interrupt CSR indices
    typedef enum logic [CSR_ADDR_WIDTH-1:0]
    {
        CSR_IE = 5'd0,
        CSR_IM = 5'd1,
        CSR_IP = 5'd2
    } csr_addr_e;

    // Layout of the IE word
    localparam int IE_BIT  = 0;  // Global enable
    localparam int EIE_BIT = 1;  // Saved on exception
    localparam int BIE_BIT = 2;  // Saved on breakpoint

endpackage

`default_nettype wire

//--- hw/irq_cfg_pkg.sv
`default_nettype none

package irq_cfg_pkg;

    // CSR data path
    localparam int WORD_WIDTH = 32;

    // External interrupt pins
    localparam int NUM_IRQ = 8;
    localparam int IRQ_ID_WIDTH = $clog2(NUM_IRQ);  // Enough bits for an index

    // Flops between a pin and the pending register
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire
